//--- all.f
common/msg_bus_pkg.sv
message_fifo/message_fifo.sv
verilog/bus_interface.sv
verilog/slave_arbiter.sv
verilog/msg_bus_top.sv
test/msg_bus_sva.sv
test/msg_bus_tb.sv

//--- common/msg_bus_pkg.sv
package msg_bus_pkg;

	// Bus widths
	localparam int byte_width = 8;
	localparam int addr_width = 8;

	// Nodes on the shared bus
	localparam int num_nodes = 2;
	localparam logic [addr_width-1:0] node0_addr = 8'h10;
	localparam logic [addr_width-1:0] node1_addr = 8'h21;

	// Message FIFO holds 16 bytes
	localparam int fifo_depth_log2 = 4;

	// FIFO writer
	typedef enum logic [1:0] {
		W_IDLE,
		W_FILL,
		W_DROP
	} wr_state_t;

	// FIFO reader, length byte comes before the data
	typedef enum logic [1:0] {
		R_IDLE,
		R_LEN,
		R_DATA
	} rd_state_t;

	// Slave bus arbiter
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

endpackage

//--- message_fifo/message_fifo.sv
`timescale 1ns/100ps

module message_fifo #(
	parameter int depth_log2    = msg_bus_pkg::fifo_depth_log2,
	parameter bit prefix_length = 1'b0
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [msg_bus_pkg::byte_width-1:0] in_data,
	input  logic                               in_data_latch,
	input  logic                               in_frame_valid,
	output logic                               in_data_overflow,
	output logic [msg_bus_pkg::byte_width-1:0] out_data,
	output logic                               out_frame_valid,
	input  logic                               out_data_latch,
	output logic                               out_last
);
	import msg_bus_pkg::*;

	localparam int depth = 1 << depth_log2;

	// Byte buffer, pointers carry one extra wrap bit
	logic [byte_width-1:0] mem [depth];
	logic [depth_log2:0]   wr_ptr;
	logic [depth_log2:0]   commit_ptr;
	logic [depth_log2:0]   rd_ptr;
	logic [depth_log2:0]   used;
	logic                  full;

	// Frame being written
	logic [depth_log2:0] frame_len;
	logic                wr_en;
	logic                commit;

	// Lengths of committed frames
	logic [depth_log2:0] len_mem [depth];
	logic [depth_log2:0] lq_wr;
	logic [depth_log2:0] lq_rd;
	logic [depth_log2:0] lq_count;
	logic [depth_log2:0] head_len;

	// Reader position inside the head frame
	logic [depth_log2:0] rd_idx;
	logic                pop_len;
	logic                pop_data;
	logic                pop_last;
	logic                more_frames;

	wr_state_t wr_state;
	rd_state_t rd_state;

	assign used = wr_ptr - rd_ptr;
	assign full = used[depth_log2];
	assign wr_en = in_frame_valid && in_data_latch && !full && (wr_state != W_DROP);
	assign commit = (wr_state == W_FILL) && !in_frame_valid && (frame_len != '0);
	assign in_data_overflow = (wr_state == W_DROP);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= W_IDLE;
			wr_ptr <= '0;
			commit_ptr <= '0;
			frame_len <= '0;
		end else begin
			case (wr_state)
				W_IDLE, W_FILL: begin
					if (in_frame_valid) begin
						wr_state <= W_FILL;
						if (in_data_latch && full) begin
							// Frame cannot fit, throw away what was stored of it
							wr_state <= W_DROP;
							wr_ptr <= commit_ptr;
							frame_len <= '0;
						end else if (in_data_latch) begin
							wr_ptr <= wr_ptr + 1'b1;
							frame_len <= frame_len + 1'b1;
						end
					end else begin
						// Envelope fell, an empty envelope leaves nothing behind
						wr_state <= W_IDLE;
						frame_len <= '0;
						if (commit)
							commit_ptr <= wr_ptr;
					end
				end
				W_DROP: begin
					if (!in_frame_valid)
						wr_state <= W_IDLE;
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[depth_log2-1:0]] <= in_data;
		// Every frame holds at least one byte, so this queue never overruns
		if (commit)
			len_mem[lq_wr[depth_log2-1:0]] <= frame_len;
	end

	assign lq_count = lq_wr - lq_rd;
	assign head_len = len_mem[lq_rd[depth_log2-1:0]];
	assign pop_len = (rd_state == R_LEN) && out_data_latch;
	assign pop_data = (rd_state == R_DATA) && out_data_latch;
	assign out_last = (rd_state == R_DATA) && (rd_idx == head_len - 1'b1);
	assign pop_last = pop_data && out_last;

	// Another frame is ready once the head frame leaves
	assign more_frames = (lq_count > 1) || commit;

	assign out_frame_valid = (rd_state != R_IDLE);
	assign out_data = (rd_state == R_LEN) ? byte_width'(head_len)
		: mem[rd_ptr[depth_log2-1:0]];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= R_IDLE;
			rd_ptr <= '0;
			rd_idx <= '0;
			lq_wr <= '0;
			lq_rd <= '0;
		end else begin
			if (commit)
				lq_wr <= lq_wr + 1'b1;
			if (pop_data) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_idx <= rd_idx + 1'b1;
			end
			case (rd_state)
				R_IDLE: begin
					if (commit)
						rd_state <= prefix_length ? R_LEN : R_DATA;
				end
				R_LEN: begin
					if (pop_len)
						rd_state <= R_DATA;
				end
				R_DATA: begin
					if (pop_last) begin
						lq_rd <= lq_rd + 1'b1;
						rd_idx <= '0;
						if (!more_frames)
							rd_state <= R_IDLE;
						else if (prefix_length)
							rd_state <= R_LEN;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

endmodule

//--- test/msg_bus_sva.sv
`timescale 1ns/100ps

module msg_bus_sva (
	input logic                                     clk,
	input logic                                     rst_n,
	input logic [msg_bus_pkg::addr_width-1:0]       ma_addr,
	input logic                                     ma_overflow,
	input logic [msg_bus_pkg::num_nodes-1:0]        in_frame_valid,
	input logic [msg_bus_pkg::num_nodes-1:0]        grant,
	input logic [msg_bus_pkg::num_nodes-1:0]        node_request,
	input logic [$clog2(msg_bus_pkg::num_nodes)-1:0] grant_index,
	input logic                                     sl_ready,
	input logic                                     sl_valid,
	input logic                                     sl_last,
	input logic [msg_bus_pkg::byte_width-1:0]       sl_data,
	input logic [$clog2(msg_bus_pkg::num_nodes)-1:0] sl_node
);
	import msg_bus_pkg::*;

	// Read by the testbench to stop the run
	int fail_count = 0;

	// One grant at a time
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
		else begin
			fail_count++;
			$error("slave bus granted to more than one node");
		end

	// Slave bus holds while stalled
	assert property (@(posedge clk) disable iff (!rst_n)
		sl_valid && !sl_ready |=> $stable(sl_data) && $stable(sl_node) && $stable(sl_last))
		else begin
			fail_count++;
			$error("slave bus changed while stalled");
		end

	// A granted node keeps its request until its frame is out
	assert property (@(posedge clk) disable iff (!rst_n)
		(|grant) |-> node_request[grant_index] && sl_valid)
		else begin
			fail_count++;
			$error("grant held without a request from the granted node");
		end

	// No node addressed, so nothing can overflow
	assert property (@(posedge clk) disable iff (!rst_n)
		ma_addr != node0_addr && ma_addr != node1_addr |-> !ma_overflow)
		else begin
			fail_count++;
			$error("ma_overflow raised for an unknown address");
		end

	assert property (@(posedge clk) !rst_n |=> !sl_valid && !ma_overflow && in_frame_valid == '0)
		else begin
			fail_count++;
			$error("outputs not cleared by reset");
		end

endmodule

bind msg_bus_top msg_bus_sva protocol_checks (
	.clk(clk),
	.rst_n(rst_n),
	.ma_addr(ma_addr),
	.ma_overflow(ma_overflow),
	.in_frame_valid(in_frame_valid),
	.grant(grant),
	.node_request(node_request),
	.grant_index(grant_index),
	.sl_ready(sl_ready),
	.sl_valid(sl_valid),
	.sl_last(sl_last),
	.sl_data(sl_data),
	.sl_node(sl_node)
);

//--- test/msg_bus_tb.sv
`timescale 1ns/100ps

module msg_bus_tb;
	import msg_bus_pkg::*;

	localparam int reset_cycles = 10;
	localparam int n_rounds = 8;
	// Longest frame of every phase including the length byte of output frames
	localparam int frame_bytes = 3 * 8 + 2 * 8 + 8 + 20 + 5 + 4 * 9 + n_rounds * 2 * 9;
	localparam int frame_count = 3 + 2 + 1 + 2 + 4 + n_rounds * 2;
	localparam int gap_cycles = frame_count * 12;
	localparam int timeout_cycles = 4 * (frame_bytes + gap_cycles) + reset_cycles;

	logic                                 clk;
	logic                                 rst_n;
	logic [byte_width-1:0]                ma_data;
	logic [addr_width-1:0]                ma_addr;
	logic                                 ma_data_valid;
	logic                                 ma_frame_valid;
	logic                                 ma_overflow;
	logic [num_nodes-1:0]                 in_frame_data_latch;
	logic [num_nodes-1:0][byte_width-1:0] in_frame_data;
	logic [num_nodes-1:0]                 in_frame_data_valid;
	logic [num_nodes-1:0]                 in_frame_valid;
	logic [num_nodes-1:0]                 in_frame_last;
	logic [num_nodes-1:0][byte_width-1:0] out_frame_data;
	logic [num_nodes-1:0]                 out_frame_valid;
	logic [num_nodes-1:0]                 out_frame_data_latch;
	logic                                 sl_ready;
	logic [byte_width-1:0]                sl_data;
	logic                                 sl_valid;
	logic                                 sl_last;
	logic [$clog2(num_nodes)-1:0]         sl_node;

	// Expected bytes with bit 8 marking the final byte of a frame
	logic [8:0]            exp0 [$];
	logic [byte_width-1:0] exp1 [$];
	logic [8:0]            exp_sl [num_nodes][$];

	logic [31:0] lfsr_state;
	string       test_name = "reset";
	int          cycle_count = 0;
	int          ready_mode = 0;
	bit          pop_next = 1'b0;
	bit          ready_next = 1'b0;
	bit          quiet = 1'b0;
	bit          saw_overflow = 1'b0;
	bit          alt_check = 1'b0;
	bit          in_sl_frame = 1'b0;
	bit          have_last = 1'b0;
	int          cur_node = 0;
	int          last_node = 0;

	msg_bus_top UUT (.*);

	always #50 clk = ~clk;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL %s expected %0h actual %0h", what, expected, actual);
		stop_run();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s", msg);
		stop_run();
	endtask

	task automatic wait_node0_drained();
		while (exp0.size() != 0)
			@(posedge clk);
	endtask

	task automatic wait_slave_drained();
		while (exp_sl[0].size() != 0 || exp_sl[1].size() != 0)
			@(posedge clk);
	endtask

	// One frame on the master bus where drop marks a frame that must not arrive
	task automatic send_ma(input logic [addr_width-1:0] addr, input int len, input bit drop);
		logic [byte_width-1:0] b;
		bit                    check_latency;
		check_latency = (addr == node0_addr) && !drop && (exp0.size() == 0);
		@(posedge clk);
		ma_addr <= addr;
		ma_frame_valid <= 1'b1;
		for (int i = 0; i < len; i++) begin
			// Idle lane cycle inside the frame now and then
			if (take_bits(1) != 0) begin
				ma_data_valid <= 1'b0;
				@(posedge clk);
			end
			b = byte_width'(take_bits(8));
			ma_data <= b;
			ma_data_valid <= 1'b1;
			if (addr == node0_addr && !drop)
				exp0.push_back({i == len - 1, b});
			else if (addr == node1_addr)
				exp1.push_back(b);
			@(posedge clk);
		end
		ma_data_valid <= 1'b0;
		ma_frame_valid <= 1'b0;
		if (check_latency || drop) begin
			@(posedge clk);
			assert (!in_frame_valid[0])
				else report_mismatch({test_name, " early in_frame_valid"}, 0, 1);
			@(posedge clk);
			assert (in_frame_valid[0] == check_latency)
				else report_mismatch({test_name, " in_frame_valid"}, check_latency, in_frame_valid[0]);
		end
	endtask

	// One outgoing frame written into a node's output FIFO
	task automatic queue_out(input int node, input int len);
		logic [byte_width-1:0] b;
		exp_sl[node].push_back({1'b0, byte_width'(len)});
		@(posedge clk);
		out_frame_valid[node] <= 1'b1;
		for (int i = 0; i < len; i++) begin
			b = byte_width'(take_bits(8));
			out_frame_data[node] <= b;
			out_frame_data_latch[node] <= 1'b1;
			exp_sl[node].push_back({i == len - 1, b});
			@(posedge clk);
		end
		out_frame_data_latch[node] <= 1'b0;
		out_frame_valid[node] <= 1'b0;
		@(posedge clk);
	endtask

	// Pop and ready bits for the next rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			pop_next = (take_bits(1) != 0);
			case (ready_mode)
				0: ready_next = 1'b0;
				1: ready_next = 1'b1;
				default: ready_next = (take_bits(1) != 0);
			endcase
		end
	end

	// Random consumer pops and slave-bus ready
	always @(posedge clk) begin
		if (!rst_n) begin
			in_frame_data_latch <= '0;
			sl_ready <= 1'b0;
		end else begin
			in_frame_data_latch[0] <= pop_next;
			sl_ready <= ready_next;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_cycles)
			report_error($sformatf("run did not finish within %0d cycles", timeout_cycles));
	end

	always @(posedge clk) begin : monitor
		logic [8:0] head;
		int         n;
		if (rst_n) begin
			if (UUT.protocol_checks.fail_count != 0)
				report_error("a protocol assertion on the DUT failed");
			if (ma_overflow)
				saw_overflow = 1'b1;
			if (quiet) begin
				assert (in_frame_valid == '0 && !ma_overflow)
					else report_error("a frame to an unknown address reached a node");
			end
			// Node 1 follows the master strobes when addressed
			assert (in_frame_valid[1] == (ma_addr == node1_addr && ma_frame_valid))
				else report_mismatch({test_name, " node1 frame valid"},
					ma_addr == node1_addr && ma_frame_valid, in_frame_valid[1]);
			assert (in_frame_data_valid[1] == (ma_addr == node1_addr && ma_data_valid))
				else report_mismatch({test_name, " node1 data valid"},
					ma_addr == node1_addr && ma_data_valid, in_frame_data_valid[1]);
			if (in_frame_data_valid[1]) begin
				if (exp1.size() == 0)
					report_error("node 1 showed a byte that was not sent to it");
				else begin
					head = {1'b0, exp1.pop_front()};
					assert (in_frame_data[1] == head[7:0])
						else report_mismatch({test_name, " node1 data"}, head[7:0], in_frame_data[1]);
				end
			end
			if (in_frame_data_latch[0] && in_frame_data_valid[0]) begin
				if (exp0.size() == 0)
					report_error("node 0 delivered a byte that was not sent to it");
				else begin
					head = exp0.pop_front();
					assert (in_frame_data[0] == head[7:0])
						else report_mismatch({test_name, " node0 data"}, head[7:0], in_frame_data[0]);
					assert (in_frame_last[0] == head[8])
						else report_mismatch({test_name, " node0 last"}, head[8], in_frame_last[0]);
				end
			end
			if (sl_valid && sl_ready) begin
				n = int'(sl_node);
				if (in_sl_frame && n != cur_node)
					report_error("slave bus frames from the two nodes interleaved");
				else if (exp_sl[n].size() == 0)
					report_error("slave bus carried a byte that no node queued");
				else begin
					if (!in_sl_frame && alt_check && have_last && exp_sl[1 - last_node].size() != 0) begin
						assert (n != last_node)
							else report_mismatch({test_name, " grant order"}, 1 - last_node, n);
					end
					head = exp_sl[n].pop_front();
					assert (sl_data == head[7:0])
						else report_mismatch({test_name, " slave data"}, head[7:0], sl_data);
					assert (sl_last == head[8])
						else report_mismatch({test_name, " slave last"}, head[8], sl_last);
					in_sl_frame = !sl_last;
					cur_node = n;
					if (sl_last) begin
						last_node = n;
						have_last = 1'b1;
					end
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		lfsr_state = 32'hb9095dd8;
		rst_n = 1'b0;
		ma_data = '0;
		ma_addr = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		in_frame_data_latch = '0;
		out_frame_data = '0;
		out_frame_valid = '0;
		out_frame_data_latch = '0;
		sl_ready = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "buffered_delivery";
		repeat (3) begin
			wait_node0_drained();
			send_ma(node0_addr, 1 + take_bits(3), 1'b0);
		end
		wait_node0_drained();

		test_name = "pass_through";
		send_ma(node1_addr, 1 + take_bits(3), 1'b0);
		send_ma(node0_addr, 1 + take_bits(3), 1'b0);
		wait_node0_drained();

		test_name = "unknown_address";
		quiet = 1'b1;
		send_ma(8'h55, 1 + take_bits(3), 1'b0);
		repeat (3) @(posedge clk);
		quiet = 1'b0;

		// 20 bytes into a 16-byte FIFO
		test_name = "overflow";
		saw_overflow = 1'b0;
		send_ma(node0_addr, 20, 1'b1);
		assert (saw_overflow)
			else report_error("no overflow reported for a frame larger than the FIFO");
		send_ma(node0_addr, 5, 1'b0);
		wait_node0_drained();

		// Both nodes loaded before the slave bus may move
		test_name = "slave_framing";
		alt_check = 1'b1;
		repeat (2) begin
			queue_out(0, 1 + take_bits(3));
			queue_out(1, 1 + take_bits(3));
		end
		ready_mode = 1;
		wait_slave_drained();
		alt_check = 1'b0;

		test_name = "back_pressure";
		ready_mode = 2;
		for (int r = 0; r < n_rounds; r++) begin
			for (int node = 0; node < num_nodes; node++) begin
				while (exp_sl[node].size() > 8)
					@(posedge clk);
				queue_out(node, 1 + take_bits(3));
			end
		end
		wait_slave_drained();
		repeat (4) @(posedge clk);

		if (UUT.protocol_checks.fail_count != 0 || exp0.size() != 0 || exp1.size() != 0)
			report_error("checks left failures or undelivered bytes at the end of the run");
		else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- verilog/bus_interface.sv
`timescale 1ns/100ps

module bus_interface #(
	parameter logic [msg_bus_pkg::addr_width-1:0] node_addr = msg_bus_pkg::node0_addr,
	parameter bit has_input_fifo = 1'b1
) (
	input  logic                               clk,
	input  logic                               rst_n,

	// Master bus
	input  logic [msg_bus_pkg::byte_width-1:0] ma_data,
	input  logic [msg_bus_pkg::addr_width-1:0] ma_addr,
	input  logic                               ma_data_valid,
	input  logic                               ma_frame_valid,
	output logic                               overflow,

	// Local input side
	output logic [msg_bus_pkg::byte_width-1:0] in_frame_data,
	output logic                               in_frame_data_valid,
	output logic                               in_frame_valid,
	output logic                               in_frame_last,
	input  logic                               in_frame_data_latch,

	// Local output side
	input  logic [msg_bus_pkg::byte_width-1:0] out_frame_data,
	input  logic                               out_frame_valid,
	input  logic                               out_frame_data_latch,

	// Slave bus
	output logic                               sl_request,
	input  logic                               sl_grant,
	input  logic                               sl_ready,
	output logic [msg_bus_pkg::byte_width-1:0] sl_byte,
	output logic                               sl_last
);
	import msg_bus_pkg::*;

	logic addr_match;

	assign addr_match = (ma_addr == node_addr);

	generate
		if (has_input_fifo) begin : g_in_fifo
			logic fifo_overflow;

			message_fifo #(
				.depth_log2(fifo_depth_log2),
				.prefix_length(1'b0)
			) in_fifo (
				.clk(clk),
				.rst_n(rst_n),
				.in_data(ma_data),
				.in_data_latch(ma_data_valid && addr_match),
				.in_frame_valid(ma_frame_valid && addr_match),
				.in_data_overflow(fifo_overflow),
				.out_data(in_frame_data),
				.out_frame_valid(in_frame_valid),
				.out_data_latch(in_frame_data_latch),
				.out_last(in_frame_last)
			);

			// Head byte is always there while a frame is held
			assign in_frame_data_valid = in_frame_valid;
			assign overflow = addr_match && fifo_overflow;
		end else begin : g_pass
			// Consumer sees the master bus directly
			assign in_frame_data = ma_data;
			assign in_frame_valid = addr_match && ma_frame_valid;
			assign in_frame_data_valid = addr_match && ma_data_valid;
			assign in_frame_last = 1'b0;
			assign overflow = 1'b0;
		end
	endgenerate

	// Outgoing frames get a length byte in front
	message_fifo #(
		.depth_log2(fifo_depth_log2),
		.prefix_length(1'b1)
	) out_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(out_frame_data),
		.in_data_latch(out_frame_data_latch),
		.in_frame_valid(out_frame_valid),
		.in_data_overflow(),
		.out_data(sl_byte),
		.out_frame_valid(sl_request),
		.out_data_latch(sl_ready && sl_grant),
		.out_last(sl_last)
	);

endmodule

//--- verilog/msg_bus_top.sv
`timescale 1ns/100ps

module msg_bus_top (
	input  logic                                                   clk,
	input  logic                                                   rst_n,

	// Master bus
	input  logic [msg_bus_pkg::byte_width-1:0]                     ma_data,
	input  logic [msg_bus_pkg::addr_width-1:0]                     ma_addr,
	input  logic                                                   ma_data_valid,
	input  logic                                                   ma_frame_valid,
	output logic                                                   ma_overflow,

	// Local sides, indexed by node
	input  logic [msg_bus_pkg::num_nodes-1:0]                      in_frame_data_latch,
	output logic [msg_bus_pkg::num_nodes-1:0][msg_bus_pkg::byte_width-1:0] in_frame_data,
	output logic [msg_bus_pkg::num_nodes-1:0]                      in_frame_data_valid,
	output logic [msg_bus_pkg::num_nodes-1:0]                      in_frame_valid,
	output logic [msg_bus_pkg::num_nodes-1:0]                      in_frame_last,
	input  logic [msg_bus_pkg::num_nodes-1:0][msg_bus_pkg::byte_width-1:0] out_frame_data,
	input  logic [msg_bus_pkg::num_nodes-1:0]                      out_frame_valid,
	input  logic [msg_bus_pkg::num_nodes-1:0]                      out_frame_data_latch,

	// Slave bus
	input  logic                                                   sl_ready,
	output logic [msg_bus_pkg::byte_width-1:0]                     sl_data,
	output logic                                                   sl_valid,
	output logic                                                   sl_last,
	output logic [$clog2(msg_bus_pkg::num_nodes)-1:0]              sl_node
);
	import msg_bus_pkg::*;

	localparam int idx_w = $clog2(num_nodes);

	logic [num_nodes-1:0]                 node_overflow;
	logic [num_nodes-1:0]                 node_request;
	logic [num_nodes-1:0]                 node_last;
	logic [num_nodes-1:0][byte_width-1:0] node_byte;
	logic [num_nodes-1:0]                 grant;
	logic [idx_w-1:0]                     grant_index;

	// Node 0 buffers its input
	bus_interface #(
		.node_addr(node0_addr),
		.has_input_fifo(1'b1)
	) node0 (
		.clk(clk),
		.rst_n(rst_n),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.overflow(node_overflow[0]),
		.in_frame_data(in_frame_data[0]),
		.in_frame_data_valid(in_frame_data_valid[0]),
		.in_frame_valid(in_frame_valid[0]),
		.in_frame_last(in_frame_last[0]),
		.in_frame_data_latch(in_frame_data_latch[0]),
		.out_frame_data(out_frame_data[0]),
		.out_frame_valid(out_frame_valid[0]),
		.out_frame_data_latch(out_frame_data_latch[0]),
		.sl_request(node_request[0]),
		.sl_grant(grant[0]),
		.sl_ready(sl_ready),
		.sl_byte(node_byte[0]),
		.sl_last(node_last[0])
	);

	// Node 1 passes frames straight through
	bus_interface #(
		.node_addr(node1_addr),
		.has_input_fifo(1'b0)
	) node1 (
		.clk(clk),
		.rst_n(rst_n),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.overflow(node_overflow[1]),
		.in_frame_data(in_frame_data[1]),
		.in_frame_data_valid(in_frame_data_valid[1]),
		.in_frame_valid(in_frame_valid[1]),
		.in_frame_last(in_frame_last[1]),
		.in_frame_data_latch(in_frame_data_latch[1]),
		.out_frame_data(out_frame_data[1]),
		.out_frame_valid(out_frame_valid[1]),
		.out_frame_data_latch(out_frame_data_latch[1]),
		.sl_request(node_request[1]),
		.sl_grant(grant[1]),
		.sl_ready(sl_ready),
		.sl_byte(node_byte[1]),
		.sl_last(node_last[1])
	);

	slave_arbiter arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.request(node_request),
		.ready(sl_ready),
		.last(sl_last),
		.grant(grant),
		.grant_index(grant_index)
	);

	// Granted node drives the slave bus
	assign sl_valid = grant[grant_index] && node_request[grant_index];
	assign sl_data = node_byte[grant_index];
	assign sl_last = node_last[grant_index];
	assign sl_node = grant_index;

	// Only the addressed node can report overflow
	assign ma_overflow = |node_overflow;

endmodule

//--- verilog/slave_arbiter.sv
`timescale 1ns/100ps

module slave_arbiter (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [msg_bus_pkg::num_nodes-1:0]         request,
	input  logic                                     ready,
	input  logic                                     last,
	output logic [msg_bus_pkg::num_nodes-1:0]         grant,
	output logic [$clog2(msg_bus_pkg::num_nodes)-1:0] grant_index
);
	import msg_bus_pkg::*;

	localparam int idx_w = $clog2(num_nodes);

	arb_state_t       state;
	logic [idx_w-1:0] next_index;
	logic             found;
	int               cand;

	// Search begins just after the node served last
	always_comb begin
		next_index = grant_index;
		found = 1'b0;
		cand = 0;
		for (int i = 1; i <= num_nodes; i++) begin
			cand = (int'(grant_index) + i) % num_nodes;
			if (!found && request[cand]) begin
				next_index = idx_w'(cand);
				found = 1'b1;
			end
		end
	end

	always_comb begin
		grant = '0;
		if (state == ARB_BUSY)
			grant[grant_index] = 1'b1;
	end

	// grant_index doubles as the last served node while idle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			grant_index <= idx_w'(num_nodes - 1);
		end else begin
			case (state)
				ARB_IDLE: begin
					if (found) begin
						state <= ARB_BUSY;
						grant_index <= next_index;
					end
				end
				ARB_BUSY: begin
					// Hold until the whole frame has gone out
					if (ready && last)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule
